//--- design/cpuPkg.sv
// CPU package: machine sizes, opcodes, and the memory and pipeline structs
package cpuPkg;

    localparam int dataWidth   = 16;
    localparam int addrWidth   = 8;
    localparam int memWords    = 256;
    localparam int regCount    = 8;
    localparam int regIdxWidth = 3;

    // Codes 4'hc to 4'hf are illegal
    typedef enum logic [3:0] {
        opAdd  = 4'h0,
        opSub  = 4'h1,
        opAnd  = 4'h2,
        opXor  = 4'h3,
        opAddi = 4'h4,
        opLd   = 4'h5,
        opSt   = 4'h6,
        opBeqz = 4'h7,
        opBnez = 4'h8,
        opJ    = 4'h9,
        opHalt = 4'ha,
        opNop  = 4'hb
    } opcodeE;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } memReqS;

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] pc;
        logic [dataWidth-1:0] instr;
    } ifIdS;

    // rs and rt carry the resolved source indices, not the raw fields
    typedef struct packed {
        logic                   valid;
        opcodeE                 op;
        logic [regIdxWidth-1:0] rd;
        logic [regIdxWidth-1:0] rs;
        logic [regIdxWidth-1:0] rt;
        logic [dataWidth-1:0]   a;
        logic [dataWidth-1:0]   b;
        logic [dataWidth-1:0]   imm;
        logic [addrWidth-1:0]   pc;
        logic                   writesReg;
    } idExS;

    typedef struct packed {
        logic                   valid;
        opcodeE                 op;
        logic [regIdxWidth-1:0] rd;
        logic [dataWidth-1:0]   result;
        logic [dataWidth-1:0]   storeData;
        logic                   writesReg;
    } exMemS;

    typedef struct packed {
        logic                   valid;
        logic [regIdxWidth-1:0] rd;
        logic [dataWidth-1:0]   data;
    } wbS;

endpackage

//--- design/unifiedMemory.sv
// Unified memory: program and data words, combinational read and clocked write
`timescale 1ns/1ps

module unifiedMemory (
    input  logic                         clk,
    input  cpuPkg::memReqS               bus,
    output logic [cpuPkg::dataWidth-1:0] rdata
);

    logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memWords];

    assign rdata = mem[bus.addr];

    always_ff @(posedge clk) begin
        if (bus.valid && bus.write) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

endmodule

//--- design/memArbiter.sv
// Memory arbiter: fixed priority of loader, then memory stage, then fetch
`timescale 1ns/1ps

module memArbiter (
    input  cpuPkg::memReqS fetchReq,
    input  cpuPkg::memReqS memReq,
    input  cpuPkg::memReqS loadReq,
    output logic           fetchGrant,
    output logic           memGrant,
    output logic           loadGrant,
    output cpuPkg::memReqS memBus
);

    assign loadGrant  = loadReq.valid;
    assign memGrant   = memReq.valid && !loadReq.valid;
    assign fetchGrant = fetchReq.valid && !memReq.valid && !loadReq.valid;

    // With no request the fetch slot passes through with valid low
    always_comb begin
        if (loadReq.valid) begin
            memBus = loadReq;
        end else if (memReq.valid) begin
            memBus = memReq;
        end else begin
            memBus = fetchReq;
        end
    end

endmodule

//--- design/fetchStage.sv
// Fetch stage: program counter, instruction fetch requests and the fetch-to-decode register
`timescale 1ns/1ps

module fetchStage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         stall,
    input  logic                         redirect,
    input  logic [cpuPkg::addrWidth-1:0] target,
    input  logic                         stop,
    input  logic                         grant,
    input  logic [cpuPkg::dataWidth-1:0] rdata,
    output cpuPkg::memReqS               req,
    output cpuPkg::ifIdS                 ifId
);

    logic [cpuPkg::addrWidth-1:0] pc;

    // Fetch is a read of address pc, never a write
    always_comb begin
        req.valid = run && !stop && !stall && !redirect;
        req.write = 1'b0;
        req.addr  = pc;
        req.wdata = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= '0;
            ifId.valid <= 1'b0;
        end else if (redirect) begin
            // Wrong-path word in ifId is dropped
            pc         <= target;
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            if (req.valid && grant) begin
                ifId.valid <= 1'b1;
                ifId.pc    <= pc;
                ifId.instr <= rdata;
                pc         <= pc + 1;
            end else begin
                // Lost the memory or not running, so send a bubble
                ifId.valid <= 1'b0;
            end
        end
    end

endmodule

//--- design/decodeStage.sv
// Decode stage: register file, instruction decode, load-use stall and the decode-to-execute register
`timescale 1ns/1ps

module decodeStage (
    input  logic                           clk,
    input  logic                           reset,
    input  cpuPkg::ifIdS                   ifId,
    input  cpuPkg::wbS                     wb,
    input  logic [cpuPkg::regIdxWidth-1:0] exLoadRd,
    input  logic                           exIsLoad,
    input  logic                           flush,
    output logic                           stall,
    output cpuPkg::idExS                   idEx
);

    logic [cpuPkg::dataWidth-1:0]   regs [cpuPkg::regCount];
    cpuPkg::opcodeE                 op;
    logic [cpuPkg::regIdxWidth-1:0] rd;
    logic [cpuPkg::regIdxWidth-1:0] srcA;
    logic [cpuPkg::regIdxWidth-1:0] srcB;
    logic                           usesA;
    logic                           usesB;
    logic                           writesReg;
    logic [cpuPkg::dataWidth-1:0]   imm;
    cpuPkg::idExS                   idNext;

    // r0 reads zero; a write-back in this cycle is passed straight through
    function automatic logic [cpuPkg::dataWidth-1:0] readReg(
        input logic [cpuPkg::regIdxWidth-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end else if (wb.valid && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        op        = cpuPkg::opcodeE'(ifId.instr[15:12]);
        rd        = ifId.instr[11:9];
        srcA      = ifId.instr[8:6];
        srcB      = ifId.instr[5:3];
        usesA     = 1'b0;
        usesB     = 1'b0;
        writesReg = 1'b0;
        imm       = {{(cpuPkg::dataWidth-6){ifId.instr[5]}}, ifId.instr[5:0]};
        case (op)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opXor: begin
                usesA     = 1'b1;
                usesB     = 1'b1;
                writesReg = 1'b1;
            end
            cpuPkg::opAddi, cpuPkg::opLd: begin
                usesA     = 1'b1;
                writesReg = 1'b1;
            end
            cpuPkg::opSt: begin
                // Store data comes from rd
                usesA = 1'b1;
                usesB = 1'b1;
                srcB  = rd;
            end
            cpuPkg::opBeqz, cpuPkg::opBnez: begin
                usesA = 1'b1;
                srcA  = rd;
            end
            cpuPkg::opJ: begin
                imm = {{(cpuPkg::dataWidth-12){ifId.instr[11]}}, ifId.instr[11:0]};
            end
            default: begin
            end
        endcase
    end

    // Load in execute has no data yet for the instruction here
    assign stall = ifId.valid && exIsLoad && exLoadRd != '0 &&
                   ((usesA && srcA == exLoadRd) || (usesB && srcB == exLoadRd));

    always_comb begin
        idNext.valid     = ifId.valid;
        idNext.op        = op;
        idNext.rd        = rd;
        idNext.rs        = srcA;
        idNext.rt        = srcB;
        idNext.a         = readReg(srcA);
        idNext.b         = readReg(srcB);
        idNext.imm       = imm;
        idNext.pc        = ifId.pc;
        idNext.writesReg = writesReg;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.valid <= 1'b0;
        end else if (flush || stall) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx <= idNext;
        end
    end

endmodule

//--- design/executeStage.sv
// Execute stage: operand forwarding, ALU, branch resolution and the execute-to-memory register
`timescale 1ns/1ps

module executeStage (
    input  logic                         clk,
    input  logic                         reset,
    input  cpuPkg::idExS                 idEx,
    input  cpuPkg::exMemS                exMemFwd,
    input  cpuPkg::wbS                   wbFwd,
    output logic                         flush,
    output logic [cpuPkg::addrWidth-1:0] target,
    output cpuPkg::exMemS                exMem
);

    logic [cpuPkg::dataWidth-1:0] opA;
    logic [cpuPkg::dataWidth-1:0] opB;
    logic [cpuPkg::dataWidth-1:0] result;
    logic                         taken;

    // Youngest producer wins; a load in exMem has no data yet
    function automatic logic [cpuPkg::dataWidth-1:0] forward(
        input logic [cpuPkg::regIdxWidth-1:0] idx,
        input logic [cpuPkg::dataWidth-1:0]   regVal,
        input cpuPkg::exMemS                  ex,
        input cpuPkg::wbS                     w
    );
        if (idx == '0) begin
            return regVal;
        end else if (ex.valid && ex.writesReg && ex.op != cpuPkg::opLd && ex.rd == idx) begin
            return ex.result;
        end else if (w.valid && w.rd == idx) begin
            return w.data;
        end
        return regVal;
    endfunction

    always_comb begin
        opA    = forward(idEx.rs, idEx.a, exMemFwd, wbFwd);
        opB    = forward(idEx.rt, idEx.b, exMemFwd, wbFwd);
        // Address and addi sum by default
        result = opA + idEx.imm;
        taken  = 1'b0;
        case (idEx.op)
            cpuPkg::opAdd:  result = opA + opB;
            cpuPkg::opSub:  result = opA - opB;
            cpuPkg::opAnd:  result = opA & opB;
            cpuPkg::opXor:  result = opA ^ opB;
            cpuPkg::opBeqz: taken = (opA == '0);
            cpuPkg::opBnez: taken = (opA != '0);
            cpuPkg::opJ:    taken = 1'b1;
            default: begin
            end
        endcase
    end

    assign flush  = idEx.valid && taken;
    assign target = idEx.pc + 1 + idEx.imm[cpuPkg::addrWidth-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.op        <= idEx.op;
            exMem.rd        <= idEx.rd;
            exMem.result    <= result;
            exMem.storeData <= opB;
            exMem.writesReg <= idEx.writesReg;
        end
    end

endmodule

//--- design/memStage.sv
// Memory stage: load and store requests, write-back register, halt and error flags
`timescale 1ns/1ps

module memStage (
    input  logic                         clk,
    input  logic                         reset,
    input  cpuPkg::exMemS                exMem,
    input  logic                         grant,
    input  logic [cpuPkg::dataWidth-1:0] rdata,
    output cpuPkg::memReqS               req,
    output cpuPkg::wbS                   wb,
    output logic                         halted,
    output logic                         err
);

    logic active;
    logic isLoad;
    logic isStore;
    logic legal;
    logic lost;

    // Nothing behind a halt or an error may retire
    assign active  = exMem.valid && !halted;
    assign isLoad  = exMem.op == cpuPkg::opLd;
    assign isStore = exMem.op == cpuPkg::opSt;

    always_comb begin
        case (exMem.op)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opXor,
            cpuPkg::opAddi, cpuPkg::opLd, cpuPkg::opSt, cpuPkg::opBeqz,
            cpuPkg::opBnez, cpuPkg::opJ, cpuPkg::opHalt, cpuPkg::opNop: legal = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        req.valid = active && (isLoad || isStore);
        req.write = isStore;
        req.addr  = exMem.result[cpuPkg::addrWidth-1:0];
        req.wdata = exMem.storeData;
    end

    // Access taken by the loader while the core runs
    assign lost = req.valid && !grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
            halted   <= 1'b0;
            err      <= 1'b0;
        end else begin
            wb.valid <= active && legal && !lost && exMem.writesReg && exMem.rd != '0;
            wb.rd    <= exMem.rd;
            wb.data  <= isLoad ? rdata : exMem.result;
            if (active && (!legal || lost)) begin
                err    <= 1'b1;
                halted <= 1'b1;
            end else if (active && exMem.op == cpuPkg::opHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- design/cpuTop.sv
// CPU top: four-stage pipeline sharing one memory with an external loader
`timescale 1ns/1ps

module cpuTop (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         loadEn,
    input  logic [cpuPkg::addrWidth-1:0] loadAddr,
    input  logic [cpuPkg::dataWidth-1:0] loadData,
    output cpuPkg::wbS                   wb,
    output logic                         halted,
    output logic                         err
);

    cpuPkg::memReqS                 fetchReq;
    cpuPkg::memReqS                 memReq;
    cpuPkg::memReqS                 loadReq;
    cpuPkg::memReqS                 memBus;
    logic                           fetchGrant;
    logic                           memGrant;
    logic [cpuPkg::dataWidth-1:0]   rdata;
    cpuPkg::ifIdS                   ifId;
    cpuPkg::idExS                   idEx;
    cpuPkg::exMemS                  exMem;
    logic                           stall;
    logic                           flush;
    logic [cpuPkg::addrWidth-1:0]   target;
    logic [cpuPkg::regIdxWidth-1:0] exLoadRd;
    logic                           exIsLoad;

    // Loader writes only while the core is held
    always_comb begin
        loadReq.valid = loadEn && !run;
        loadReq.write = 1'b1;
        loadReq.addr  = loadAddr;
        loadReq.wdata = loadData;
    end

    // Load currently in execute, one ahead of decode
    assign exLoadRd = idEx.rd;
    assign exIsLoad = idEx.valid && idEx.op == cpuPkg::opLd;

    fetchStage fetch0 (
        .clk(clk), .reset(reset), .run(run), .stall(stall), .redirect(flush),
        .target(target), .stop(halted || err), .grant(fetchGrant), .rdata(rdata),
        .req(fetchReq), .ifId(ifId));

    decodeStage decode0 (
        .clk(clk), .reset(reset), .ifId(ifId), .wb(wb), .exLoadRd(exLoadRd),
        .exIsLoad(exIsLoad), .flush(flush), .stall(stall), .idEx(idEx));

    executeStage execute0 (
        .clk(clk), .reset(reset), .idEx(idEx), .exMemFwd(exMem), .wbFwd(wb),
        .flush(flush), .target(target), .exMem(exMem));

    memStage mem0 (
        .clk(clk), .reset(reset), .exMem(exMem), .grant(memGrant), .rdata(rdata),
        .req(memReq), .wb(wb), .halted(halted), .err(err));

    // Loader outranks everyone, so its grant has no return path
    memArbiter arb0 (
        .fetchReq(fetchReq), .memReq(memReq), .loadReq(loadReq),
        .fetchGrant(fetchGrant), .memGrant(memGrant), .loadGrant(),
        .memBus(memBus));

    unifiedMemory memory0 (
        .clk(clk), .bus(memBus), .rdata(rdata));

endmodule

//--- tests/isaModel.svh
// ISA reference model: runs the program image in order and queues the expected write-backs

logic [15:0] modelRegs [cpuPkg::regCount];
logic [15:0] modelMem [cpuPkg::memWords];
logic [2:0]  expRd [$];
logic [15:0] expData [$];
logic        modelErr;

function automatic logic [15:0] imm6(input logic [15:0] instr);
    return {{10{instr[5]}}, instr[5:0]};
endfunction

function automatic logic [15:0] imm12(input logic [15:0] instr);
    return {{4{instr[11]}}, instr[11:0]};
endfunction

// r0 stays zero and its writes never retire
function automatic void writeReg(input logic [2:0] idx, input logic [15:0] value);
    if (idx != 3'd0) begin
        modelRegs[idx] = value;
        expRd.push_back(idx);
        expData.push_back(value);
    end
endfunction

task automatic runModel();
    logic [7:0]  pc;
    logic [15:0] instr;
    logic [2:0]  rd;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] sum;
    logic [15:0] off;
    logic        done;
    int          steps;
    pc = 8'd0;
    done = 1'b0;
    steps = 0;
    modelErr = 1'b0;
    expRd.delete();
    expData.delete();
    for (int i = 0; i < cpuPkg::regCount; i++) begin
        modelRegs[3'(i)] = 16'd0;
    end
    for (int i = 0; i < cpuPkg::memWords; i++) begin
        modelMem[8'(i)] = progImage[8'(i)];
    end
    while (!done && steps < 4 * cpuPkg::memWords) begin
        instr = modelMem[pc];
        rd = instr[11:9];
        a = modelRegs[instr[8:6]];
        b = modelRegs[instr[5:3]];
        // Address or addi sum, base is rs
        sum = a + imm6(instr);
        off = 16'd0;
        pc = pc + 8'd1;
        case (cpuPkg::opcodeE'(instr[15:12]))
            cpuPkg::opAdd:  writeReg(rd, a + b);
            cpuPkg::opSub:  writeReg(rd, a - b);
            cpuPkg::opAnd:  writeReg(rd, a & b);
            cpuPkg::opXor:  writeReg(rd, a ^ b);
            cpuPkg::opAddi: writeReg(rd, sum);
            cpuPkg::opLd:   writeReg(rd, modelMem[sum[7:0]]);
            cpuPkg::opSt:   modelMem[sum[7:0]] = modelRegs[rd];
            cpuPkg::opBeqz: begin
                if (modelRegs[rd] == 16'd0) begin
                    off = imm6(instr);
                end
            end
            cpuPkg::opBnez: begin
                if (modelRegs[rd] != 16'd0) begin
                    off = imm6(instr);
                end
            end
            cpuPkg::opJ:    off = imm12(instr);
            cpuPkg::opHalt: done = 1'b1;
            cpuPkg::opNop: begin
            end
            default: begin
                // Illegal code stops the machine with nothing written
                modelErr = 1'b1;
                done = 1'b1;
            end
        endcase
        pc = pc + off[7:0];
        steps++;
    end
endtask

//--- tests/cpuTb.sv
// Testbench for the pipelined CPU: random programs compared against an ISA model
`timescale 1ns/1ps

module cpuTb;

    localparam int dataBase = 224;
    localparam int runLimit = 2000;

    logic                         clk;
    logic                         reset;
    logic                         run;
    logic                         loadEn;
    logic [cpuPkg::addrWidth-1:0] loadAddr;
    logic [cpuPkg::dataWidth-1:0] loadData;
    cpuPkg::wbS                   wb;
    logic                         halted;
    logic                         err;
    integer                       seed;
    logic [15:0]                  progImage [cpuPkg::memWords];

    `include "isaModel.svh"

    cpuTop uut (
        .clk(clk), .reset(reset), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .wb(wb), .halted(halted), .err(err));

    always #4 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        if (got !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                               name, got, expected));
        end
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [15:0] encode(
        input cpuPkg::opcodeE op,
        input logic [2:0]     rd,
        input logic [2:0]     rs,
        input logic [5:0]     low
    );
        return {op, rd, rs, low};
    endfunction

    // Register setup, random body with forward branches only, then the end word
    task automatic buildProgram(input int bodyLen, input bit endIllegal);
        int         haltIdx;
        int         maxOff;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        haltIdx = 16 + bodyLen;
        for (int i = 0; i < 16; i++) begin
            rs = (i < 7) ? 3'd0 : 3'(randBelow(8));
            progImage[8'(i)] = encode(cpuPkg::opAddi, 3'((i % 7) + 1), rs,
                                      6'(randBelow(64)));
        end
        for (int p = 16; p < haltIdx; p++) begin
            rd = 3'(randBelow(8));
            rs = 3'(randBelow(8));
            rt = 3'(randBelow(8));
            maxOff = haltIdx - p - 1;
            if (maxOff > 7) begin
                maxOff = 7;
            end
            case (randBelow(10))
                4: progImage[8'(p)] = encode(cpuPkg::opAddi, rd, rs, 6'(randBelow(64)));
                // Base r0 and a negative offset land in the data area
                5: progImage[8'(p)] = encode(cpuPkg::opLd, rd, 3'd0, {1'b1, 5'(randBelow(32))});
                6: progImage[8'(p)] = encode(cpuPkg::opSt, rd, 3'd0, {1'b1, 5'(randBelow(32))});
                7: begin
                    progImage[8'(p)] = encode(randBelow(2) == 0 ? cpuPkg::opBeqz : cpuPkg::opBnez,
                                              rd, 3'd0, 6'(randBelow(maxOff + 1)));
                end
                8: progImage[8'(p)] = {cpuPkg::opJ, 12'(randBelow(maxOff + 1))};
                default: begin
                    progImage[8'(p)] = encode(cpuPkg::opcodeE'(4'(randBelow(4))), rd, rs,
                                              {rt, 3'd0});
                end
            endcase
        end
        progImage[8'(haltIdx)] = endIllegal ? {4'(12 + randBelow(4)), 12'h000} : 16'ha000;
        // Halt words up to the data area, then data tagged by address
        for (int a = haltIdx + 1; a < cpuPkg::memWords; a++) begin
            if (a >= dataBase) begin
                progImage[8'(a)] = {8'(a), 8'(a) ^ 8'h5a};
            end else begin
                progImage[8'(a)] = {8'ha0, 8'(a)};
            end
        end
    endtask

    task automatic resetCpu();
        @(posedge clk);
        #1;
        reset = 1'b1;
        run = 1'b0;
        loadEn = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        checkValue("wb.valid after reset", 32'(wb.valid), 32'd0);
        checkValue("halted after reset", 32'(halted), 32'd0);
        checkValue("err after reset", 32'(err), 32'd0);
    endtask

    // One word per cycle through the loader port while the core is held
    task automatic loadImage();
        for (int a = 0; a < cpuPkg::memWords; a++) begin
            @(posedge clk);
            #1;
            loadEn = 1'b1;
            loadAddr = 8'(a);
            loadData = progImage[8'(a)];
            @(negedge clk);
            checkValue("wb.valid while loading", 32'(wb.valid), 32'd0);
        end
        @(posedge clk);
        #1;
        loadEn = 1'b0;
    endtask

    task automatic runAndCompare();
        int cycles;
        @(posedge clk);
        #1;
        run = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (wb.valid) begin
                if (expRd.size() == 0) begin
                    abortRun("A register write retired that the model does not expect");
                end else begin
                    checkValue("wb.rd", 32'(wb.rd), 32'(expRd.pop_front()));
                    checkValue("wb.data", 32'(wb.data), 32'(expData.pop_front()));
                end
            end
            if (!halted && cycles >= runLimit) begin
                abortRun("Timed out waiting for halted after run went high");
            end
        end while (!halted);
        checkValue("pending expected writes", 32'(expRd.size()), 32'd0);
        checkValue("err", 32'(err), 32'(modelErr));
        // Pipeline stays quiet after the halt
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            checkValue("wb.valid after halt", 32'(wb.valid), 32'd0);
            checkValue("halted", 32'(halted), 32'd1);
        end
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        run = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        seed = 33;
        // Long random program ending in a halt
        buildProgram(60, 1'b0);
        runModel();
        resetCpu();
        loadImage();
        runAndCompare();
        // Short program ending in an illegal opcode
        buildProgram(8, 1'b1);
        runModel();
        resetCpu();
        loadImage();
        runAndCompare();
        $display("Test passed");
        $finish;
    end

endmodule

//--- pipeCpu.f
+incdir+tests
design/cpuPkg.sv
design/unifiedMemory.sv
design/memArbiter.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memStage.sv
design/cpuTop.sv
tests/cpuTb.sv

//--- Makefile
# Verilator flow for the pipeCpu testbench

TOP := cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f pipeCpu.f --top-module $(TOP)

sim:
	verilator --binary --timing -f pipeCpu.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
